// File: rtl/z3Config.svh
// autoconfig identity, card window sizes and autoconfig register offsets
`ifndef Z3_CONFIG_SVH
`define Z3_CONFIG_SVH

// configuration space is FF00xxxx, upper address half only
`define Z3_CFG_SPACE 16'hFF00

// identity served by the nibble ROM
`define Z3_PRODUCT 8'h2A
`define Z3_MANUFACTURER 16'h1D2C
`define Z3_SERIAL 32'h5A3C0001

// er_Type: Zorro III, link into free memory pool, size code 000
// size code 000 together with the extended-size flag means 16 MB
`define Z3_ER_TYPE 8'hA0

// er_Flags: extended size, Zorro III sub-size
`define Z3_ER_FLAGS 8'h30

// card window is one 16 MB slot, selected by A31..A24
`define Z3_CARD_BITS 24

// writable registers, byte offsets inside configuration space
// base address, data bits 31..24 hold the slot
`define Z3_REG_BASE 9'h044
// shut-up command, any data
`define Z3_REG_SHUTUP 9'h04C

`endif

// File: rtl/z3BusPkg.sv
// Zorro III bus types, cycle state enum and the latched cycle struct
package z3BusPkg;

	// full bus address, AD31..AD8 plus A7..A2
	typedef logic [31:0] z3AddrT;

	// logical data word D31..D0
	typedef logic [31:0] z3DataT;

	// card slot, A31..A24
	typedef logic [7:0] z3BaseT;

	// autoconfig index, A8..A2
	// bit 6 is A8 and picks the nibble, bits 5..0 pick the register
	typedef logic [6:0] z3RegT;

	// one ROM nibble, served on D31..D28
	typedef logic [3:0] z3NibbleT;

	// memory space code FC1..FC0
	typedef logic [1:0] z3FcT;

	// /DS3../DS0, active low
	// /DS3 strobes D31..D24
	typedef logic [3:0] z3StrobeT;

	// bus cycle as seen by the slave
	typedef enum logic [2:0] {
		Idle,
		Match,
		Data,
		WriteLatch,
		Dtack
	} z3StateT;

	// latched once per full cycle
	// READ and FC stay valid all cycle, kept here with the address anyway
	typedef struct packed {
		z3AddrT addr;
		logic read;
		z3FcT fc;
	} z3CycleT;

endpackage

// File: rtl/wbPkg.sv
// Wishbone classic request and response structs with their field types
package wbPkg;

	// 32-bit word address inside the 16 MB card window
	typedef logic [21:0] wbAdrT;

	// byte selects, sel[3] is dat[31:24]
	typedef logic [3:0] wbSelT;

	// data word on both directions
	typedef logic [31:0] wbDatT;

	// master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wbAdrT adr;
		wbSelT sel;
		wbDatT dat;
	} wbReqT;

	// slave to master
	// ack only means something while cyc and stb are high
	typedef struct packed {
		logic ack;
		wbDatT dat;
	} wbRspT;

endpackage

// File: rtl/z3AddrDecode.sv
// address capture, card and configuration space match, /SLAVEN
`timescale 1ns/1ps
`include "z3Config.svh"

module z3AddrDecode import z3BusPkg::*; (
	input  logic        clk,
	input  logic        nIORST,
	input  logic        capture_i,
	input  logic [23:0] ad_i,
	input  logic [5:0]  a_i,
	input  logic        read_i,
	input  z3FcT        fc_i,
	input  logic        nFCS_i,
	input  z3BaseT      base_i,
	input  logic        configured_i,
	input  logic        shutup_i,
	input  logic        nCfgIn_i,
	output z3CycleT     cycle_o,
	output logic        cardHit_o,
	output logic        cfgHit_o,
	output logic        nSlave_o
);

	z3CycleT cycleQ;
	logic captureQ;
	logic selQ;
	logic spaceOk;
	logic cardMatch;
	logic cfgMatch;

	// AD lines go tristate soon after /FCS falls
	// A7..A2, READ and FC would hold, but one latch keeps it simple
	always_ff @(posedge clk) begin
		if (capture_i) begin
			cycleQ.addr <= {ad_i, a_i, 2'b00};
			cycleQ.read <= read_i;
			cycleQ.fc <= fc_i;
		end
	end

	// user data or user program space only
	assign spaceOk = ((cycleQ.fc == 2'b01) || (cycleQ.fc == 2'b10)) && !shutup_i;

	// 16 MB slot compare
	assign cardMatch = (cycleQ.addr[31:`Z3_CARD_BITS] == base_i);
	assign cfgMatch = (cycleQ.addr[31:16] == `Z3_CFG_SPACE);

	assign cardHit_o = configured_i && cardMatch && spaceOk;
	// unconfigured and our turn in the chain
	assign cfgHit_o = !configured_i && !nCfgIn_i && cfgMatch && spaceOk;

	assign cycle_o = cycleQ;

	// select is taken one clock after capture and held for the cycle
	// so a config write that sets configured does not drop /SLAVEN early
	always_ff @(posedge clk) begin
		if (!nIORST) begin
			captureQ <= 1'b0;
			selQ <= 1'b0;
		end else begin
			captureQ <= capture_i;
			if (nFCS_i) begin
				selQ <= 1'b0;
			end else if (captureQ) begin
				selQ <= cardHit_o || cfgHit_o;
			end
		end
	end

	// released as soon as the master lets go of /FCS
	assign nSlave_o = !selQ || nFCS_i;

endmodule

// File: rtl/z3Autoconfig.sv
// autoconfig nibble ROM, base and shut-up registers, configuration chain out
`timescale 1ns/1ps
`include "z3Config.svh"

module z3Autoconfig import z3BusPkg::*; (
	input  logic     clk,
	input  logic     nIORST,
	input  logic     sense_i,
	input  logic     nCfgIn_i,
	input  z3RegT    regIdx_i,
	input  logic     cfgWrite_i,
	input  z3DataT   wdata_i,
	output z3NibbleT romNibble_o,
	output z3BaseT   base_o,
	output logic     configured_o,
	output logic     shutup_o,
	output logic     nCfgOut_o
);

	localparam logic [8:0] regBaseOff = `Z3_REG_BASE;
	localparam logic [8:0] regShutupOff = `Z3_REG_SHUTUP;
	localparam logic [15:0] manufacturer = `Z3_MANUFACTURER;
	localparam logic [31:0] serial = `Z3_SERIAL;

	logic [7:0] romByte;
	logic romTrue;
	z3NibbleT nibble;
	z3BaseT baseQ;
	logic configuredQ;
	logic shutupQ;
	logic wrBase;
	logic wrShutup;

	// register byte per A7..A2
	// A8 then picks high nibble (0) or low nibble (1)
	always_comb begin
		case (regIdx_i[5:0])
			// 00 er_Type
			6'h00: romByte = `Z3_ER_TYPE;
			// 04 er_Product
			6'h01: romByte = `Z3_PRODUCT;
			// 08 er_Flags
			6'h02: romByte = `Z3_ER_FLAGS;
			// 10 / 14 manufacturer, high byte first
			6'h04: romByte = manufacturer[15:8];
			6'h05: romByte = manufacturer[7:0];
			// 18..24 serial number, msb first
			6'h06: romByte = serial[31:24];
			6'h07: romByte = serial[23:16];
			6'h08: romByte = serial[15:8];
			6'h09: romByte = serial[7:0];
			// reserved and unused read as zero before inversion
			default: romByte = 8'h00;
		endcase
	end

	assign nibble = regIdx_i[6] ? romByte[3:0] : romByte[7:4];

	// only er_Type and the interrupt register read true
	assign romTrue = (regIdx_i[5:0] == 6'h00) || (regIdx_i[5:0] == 6'h10);
	assign romNibble_o = romTrue ? nibble : ~nibble;

	// register writes, only while we own the chain
	assign wrBase = cfgWrite_i && !nCfgIn_i && (regIdx_i == regBaseOff[8:2]);
	assign wrShutup = cfgWrite_i && !nCfgIn_i && (regIdx_i == regShutupOff[8:2]);

	always_ff @(posedge clk) begin
		if (!nIORST) begin
			baseQ <= '0;
			configuredQ <= 1'b0;
			shutupQ <= 1'b0;
		end else begin
			// base write ends autoconfig for this card
			if (wrBase) begin
				baseQ <= wdata_i[31:24];
				configuredQ <= 1'b1;
			end
			// Zorro II backplane: stay off the bus entirely
			if (wrShutup || !sense_i) begin
				shutupQ <= 1'b1;
			end
		end
	end

	assign base_o = baseQ;
	assign configured_o = configuredQ;
	assign shutup_o = shutupQ;

	// pass the chain on once done, or right away in a Zorro II slot
	assign nCfgOut_o = !(configuredQ || shutupQ || !sense_i);

endmodule

// File: rtl/z3CycleFsm.sv
// Zorro III cycle FSM, Wishbone master sequencing, /DTACK and data latches
`timescale 1ns/1ps

module z3CycleFsm import z3BusPkg::*, wbPkg::*; (
	input  logic     clk,
	input  logic     nIORST,
	input  logic     nFCS_i,
	input  logic     DOE_i,
	input  z3StrobeT nDs_i,
	input  z3CycleT  cycle_i,
	input  logic     cardHit_i,
	input  logic     cfgHit_i,
	input  z3DataT   busWord_i,
	input  wbRspT    wbRsp_i,
	output logic     capture_o,
	output z3StateT  state_o,
	output logic     cfgWrite_o,
	output z3DataT   wdata_o,
	output z3DataT   rdata_o,
	output wbReqT    wbReq_o,
	output logic     nDtack_o
);

	z3StateT state;
	logic nFcsQ;
	z3DataT wdataQ;
	z3DataT rdataQ;
	z3StrobeT dsQ;
	logic anyDs;
	logic wbActive;
	logic ack;

	// write data is on the bus once any strobe falls
	assign anyDs = (nDs_i != 4'hF);
	assign ack = wbRsp_i.ack;

	// first clock that samples /FCS low
	assign capture_o = (state == Idle) && !nFCS_i && nFcsQ;

	// card reads request in Data, card writes in WriteLatch
	assign wbActive = cardHit_i &&
		(((state == Data) && cycle_i.read) || (state == WriteLatch));

	always_ff @(posedge clk) begin
		if (!nIORST) begin
			state <= Idle;
			nFcsQ <= 1'b1;
		end else begin
			nFcsQ <= nFCS_i;
			case (state)
				Idle: begin
					// decode is valid the clock after capture
					// unselected cycles just sit here until /FCS goes up
					if (!nFCS_i && !nFcsQ && (cardHit_i || cfgHit_i)) begin
						state <= Match;
					end
				end
				Match: begin
					// master may give up before data time
					if (nFCS_i) begin
						state <= Idle;
					end else if (DOE_i) begin
						state <= Data;
					end
				end
				Data: begin
					if (cycle_i.read) begin
						// ROM data is ready at once, memory waits for ack
						if (!cardHit_i || ack) begin
							state <= Dtack;
						end
					end else if (anyDs) begin
						state <= WriteLatch;
					end
				end
				WriteLatch: begin
					if (!cardHit_i || ack) begin
						state <= Dtack;
					end
				end
				Dtack: begin
					if (nFCS_i) begin
						state <= Idle;
					end
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// write word and strobes, taken as the strobes fall
	// memory read word, taken with ack
	always_ff @(posedge clk) begin
		if ((state == Data) && !cycle_i.read && anyDs) begin
			wdataQ <= busWord_i;
			dsQ <= nDs_i;
		end
		if ((state == Data) && cycle_i.read && wbActive && ack) begin
			rdataQ <= wbRsp_i.dat;
		end
	end

	// classic cycle, held until ack, gone the clock after
	always_comb begin
		wbReq_o.cyc = wbActive;
		wbReq_o.stb = wbActive;
		wbReq_o.we = !cycle_i.read;
		wbReq_o.adr = cycle_i.addr[23:2];
		// reads follow the live strobes, writes the latched ones
		wbReq_o.sel = cycle_i.read ? ~nDs_i : ~dsQ;
		wbReq_o.dat = wdataQ;
	end

	// one clock, WriteLatch never repeats for configuration space
	assign cfgWrite_o = (state == WriteLatch) && cfgHit_i;
	assign wdata_o = wdataQ;
	assign rdata_o = rdataQ;
	assign state_o = state;

	assign nDtack_o = !((state == Dtack) && !nFCS_i);

endmodule

// File: rtl/z3DataLanes.sv
// Zorro III byte-lane order, read source select and data output enable
`timescale 1ns/1ps

module z3DataLanes import z3BusPkg::*; (
	input  logic [23:0] adIn_i,
	input  logic [7:0]  sdIn_i,
	input  logic        nSlave_i,
	input  logic        DOE_i,
	input  logic        read_i,
	input  logic        configured_i,
	input  z3NibbleT    romNibble_i,
	input  z3DataT      rdata_i,
	output z3DataT      busWord_o,
	output logic [23:0] adOut_o,
	output logic [7:0]  sdOut_o,
	output logic        dataOe_o
);

	z3DataT readWord;

	// adIn_i[23:0] are AD31..AD8
	// D31..D24 on AD31..AD24
	// D23..D16 on SD7..SD0
	// D15..D0 on AD23..AD8
	assign busWord_o = {adIn_i[23:16], sdIn_i, adIn_i[15:0]};

	// autoconfig answers on D31..D28 only
	// rest of the word stays zero
	assign readWord = configured_i ? rdata_i : {romNibble_i, 28'h0};

	// same lane order on the way out
	assign adOut_o[23:16] = readWord[31:24];
	assign sdOut_o = readWord[23:16];
	assign adOut_o[15:0] = readWord[15:0];

	// drive only when selected, master allows it, and it is a read
	assign dataOe_o = !nSlave_i && DOE_i && read_i;

endmodule

// File: rtl/z3Slave.sv
// Zorro III slave top: decode, autoconfig, cycle FSM and data lanes
`timescale 1ns/1ps

module z3Slave import z3BusPkg::*, wbPkg::*; (
	input  logic        clk,
	input  logic        nIORST,
	input  logic        sense_i,
	input  logic        nCfgIn_i,
	input  logic        read_i,
	input  logic [23:0] ad_i,
	input  logic [5:0]  a_i,
	input  z3FcT        fc_i,
	input  logic        nFCS_i,
	input  logic        DOE_i,
	input  z3StrobeT    nDs_i,
	input  logic [7:0]  sdIn_i,
	input  wbRspT       wbRsp_i,
	output logic        nCfgOut_o,
	output logic        nSlave_o,
	output logic        nDtack_o,
	output logic [23:0] adOut_o,
	output logic [7:0]  sdOut_o,
	output logic        dataOe_o,
	output wbReqT       wbReq_o
);

	z3CycleT cycle;
	logic capture;
	logic cardHit;
	logic cfgHit;
	logic configured;
	logic shutup;
	z3BaseT base;
	z3NibbleT romNibble;
	logic cfgWrite;
	z3DataT cfgWdata;
	z3DataT rdata;
	z3DataT busWord;

	// latched address against base and configuration space
	z3AddrDecode decode (
		.clk          (clk),
		.nIORST       (nIORST),
		.capture_i    (capture),
		.ad_i         (ad_i),
		.a_i          (a_i),
		.read_i       (read_i),
		.fc_i         (fc_i),
		.nFCS_i       (nFCS_i),
		.base_i       (base),
		.configured_i (configured),
		.shutup_i     (shutup),
		.nCfgIn_i     (nCfgIn_i),
		.cycle_o      (cycle),
		.cardHit_o    (cardHit),
		.cfgHit_o     (cfgHit),
		.nSlave_o     (nSlave_o)
	);

	// register index is A8..A2 of the latched cycle
	z3Autoconfig autoconfig (
		.clk          (clk),
		.nIORST       (nIORST),
		.sense_i      (sense_i),
		.nCfgIn_i     (nCfgIn_i),
		.regIdx_i     (cycle.addr[8:2]),
		.cfgWrite_i   (cfgWrite),
		.wdata_i      (cfgWdata),
		.romNibble_o  (romNibble),
		.base_o       (base),
		.configured_o (configured),
		.shutup_o     (shutup),
		.nCfgOut_o    (nCfgOut_o)
	);

	// state is internal to the FSM
	z3CycleFsm fsm (
		.clk        (clk),
		.nIORST     (nIORST),
		.nFCS_i     (nFCS_i),
		.DOE_i      (DOE_i),
		.nDs_i      (nDs_i),
		.cycle_i    (cycle),
		.cardHit_i  (cardHit),
		.cfgHit_i   (cfgHit),
		.busWord_i  (busWord),
		.wbRsp_i    (wbRsp_i),
		.capture_o  (capture),
		.state_o    (),
		.cfgWrite_o (cfgWrite),
		.wdata_o    (cfgWdata),
		.rdata_o    (rdata),
		.wbReq_o    (wbReq_o),
		.nDtack_o   (nDtack_o)
	);

	// direction comes from the latched READ
	z3DataLanes lanes (
		.adIn_i       (ad_i),
		.sdIn_i       (sdIn_i),
		.nSlave_i     (nSlave_o),
		.DOE_i        (DOE_i),
		.read_i       (cycle.read),
		.configured_i (configured),
		.romNibble_i  (romNibble),
		.rdata_i      (rdata),
		.busWord_o    (busWord),
		.adOut_o      (adOut_o),
		.sdOut_o      (sdOut_o),
		.dataOe_o     (dataOe_o)
	);

endmodule

// File: test/z3SlaveTb.sv
// testbench with Zorro III master and Wishbone memory models, stimulus table, LFSR, timeout
`timescale 1ns/1ps
`include "z3Config.svh"

module z3SlaveTb import z3BusPkg::*, wbPkg::*;;

	// one full bus cycle, or a reset when isReset is set
	typedef struct packed {
		logic [95:0] name;
		logic isReset;
		z3AddrT addr;
		logic read;
		z3FcT fc;
		z3StrobeT ds;
		z3DataT wdata;
		logic expSlave;
		z3DataT expData;
		logic expCfgOut;
	} rowT;

	localparam logic [7:0] erType = `Z3_ER_TYPE;
	localparam logic [7:0] product = `Z3_PRODUCT;

	logic clk;
	logic nIORST;
	logic sense;
	logic nCfgIn;
	logic readIn;
	logic [23:0] adIn;
	logic [5:0] aIn;
	z3FcT fc;
	logic nFCS;
	logic DOE;
	z3StrobeT nDs;
	logic [7:0] sdIn;
	wbRspT wbRsp;
	logic nCfgOut;
	logic nSlave;
	logic nDtack;
	logic [23:0] adOut;
	logic [7:0] sdOut;
	logic dataOe;
	wbReqT wbReq;

	rowT rows [0:31];
	rowT cur;
	int rowCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	int wbCount = 0;
	int ackDelay;
	logic [7:0] lfsr = 8'd78;
	logic [31:0] mem [0:255];

	z3Slave DUT (
		.clk       (clk),
		.nIORST    (nIORST),
		.sense_i   (sense),
		.nCfgIn_i  (nCfgIn),
		.read_i    (readIn),
		.ad_i      (adIn),
		.a_i       (aIn),
		.fc_i      (fc),
		.nFCS_i    (nFCS),
		.DOE_i     (DOE),
		.nDs_i     (nDs),
		.sdIn_i    (sdIn),
		.wbRsp_i   (wbRsp),
		.nCfgOut_o (nCfgOut),
		.nSlave_o  (nSlave),
		.nDtack_o  (nDtack),
		.adOut_o   (adOut),
		.sdOut_o   (sdOut),
		.dataOe_o  (dataOe),
		.wbReq_o   (wbReq)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic stopRun();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic compareValue(input logic [95:0] name, input string what,
		input logic [31:0] expVal, input logic [31:0] actVal);
		assert (actVal === expVal) else begin
			$display("ERR %0s %0s expected %h actual %h", name, what, expVal, actVal);
			stopRun();
		end
	endtask

	task automatic requireTrue(input logic cond, input logic [95:0] name, input string text);
		assert (cond === 1'b1) else begin
			$display("%0s: %0s", name, text);
			stopRun();
		end
	endtask

	// right shifting Galois form of x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsrStep(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	// ROM answer on D31..D28 complemented except for er_Type
	function automatic z3DataT nibbleWord(input logic [7:0] b, input logic lowHalf,
		input logic inverted);
		logic [3:0] n;
		n = lowHalf ? b[3:0] : b[7:4];
		if (inverted) begin
			n = ~n;
		end
		return {n, 28'h0};
	endfunction

	task automatic addRow(input logic [95:0] name, input logic isReset, input z3AddrT addr,
		input logic read, input z3FcT fc, input z3StrobeT ds, input z3DataT wdata,
		input logic expSlave, input z3DataT expData, input logic expCfgOut);
		rows[rowCount] = {name, isReset, addr, read, fc, ds, wdata, expSlave, expData, expCfgOut};
		rowCount++;
	endtask

	// cycle budget grows with the table
	always @(posedge clk) begin
		cycleCount++;
		if ((cycleLimit > 0) && (cycleCount > cycleLimit)) begin
			$display("timeout after %0d cycles, the bus cycle never completed", cycleCount);
			stopRun();
		end
	end

	// memory behind the Wishbone port with ack after 0..3 clocks
	always begin
		@(negedge clk);
		if (wbReq.cyc && wbReq.stb) begin
			ackDelay = 0;
			for (int b = 0; b < 2; b++) begin
				ackDelay = (ackDelay << 1) | lfsr[0];
				lfsr = lfsrStep(lfsr);
			end
			repeat (ackDelay) @(negedge clk);
			wbCount++;
			compareValue(cur.name, "wb adr", {10'h0, cur.addr[23:2]}, {10'h0, wbReq.adr});
			compareValue(cur.name, "wb sel", {28'h0, ~cur.ds}, {28'h0, wbReq.sel});
			if (wbReq.we) begin
				compareValue(cur.name, "wb wdata", cur.wdata, wbReq.dat);
				// sel[i] strobes byte i
				for (int i = 0; i < 4; i++) begin
					if (wbReq.sel[i]) begin
						mem[wbReq.adr[7:0]][8*i +: 8] = wbReq.dat[8*i +: 8];
					end
				end
			end else begin
				wbRsp.dat = mem[wbReq.adr[7:0]];
			end
			wbRsp.ack = 1'b1;
			@(negedge clk);
			wbRsp.ack = 1'b0;
		end
	end

	task automatic applyReset(input rowT r);
		@(negedge clk);
		nIORST = 1'b0;
		nFCS = 1'b1;
		DOE = 1'b0;
		nDs = 4'hF;
		repeat (5) @(negedge clk);
		nIORST = 1'b1;
		@(negedge clk);
		requireTrue(nSlave && nDtack && !wbReq.cyc && !wbReq.stb && !dataOe, r.name,
			"bus and Wishbone outputs are not idle after reset");
		compareValue(r.name, "nCfgOut", {31'h0, r.expCfgOut}, {31'h0, nCfgOut});
	endtask

	task automatic applyCycle(input rowT r);
		logic seen;
		logic cardAccess;
		int wbBefore;
		int waitCount;
		seen = 1'b0;
		wbBefore = wbCount;
		cardAccess = r.expSlave && (r.addr[31:16] != `Z3_CFG_SPACE);
		// address phase
		@(negedge clk);
		adIn = r.addr[31:8];
		aIn = r.addr[7:2];
		readIn = r.read;
		fc = r.fc;
		sdIn = 8'h00;
		nFCS = 1'b0;
		// /SLAVEN or two clocks
		for (int i = 0; (i < 2) && !seen; i++) begin
			@(negedge clk);
			seen = !nSlave;
		end
		requireTrue(seen == r.expSlave, r.name,
			seen ? "card answered an address it should ignore" : "card did not assert SLAVEN");
		// data phase
		// D31..24 on AD31..24, D23..16 on SD, D15..0 on AD23..8
		DOE = 1'b1;
		nDs = r.ds;
		if (!r.read) begin
			adIn = {r.wdata[31:24], r.wdata[15:0]};
			sdIn = r.wdata[23:16];
		end
		if (r.expSlave) begin
			waitCount = 0;
			while (nDtack && (waitCount < 20)) begin
				@(negedge clk);
				waitCount++;
			end
			requireTrue(!nDtack, r.name, "card never asserted DTACK");
			// data pins driven on reads only
			compareValue(r.name, "dataOe", {31'h0, r.read}, {31'h0, dataOe});
			if (r.read) begin
				compareValue(r.name, "read data", r.expData, {adOut[23:16], sdOut, adOut[15:0]});
			end
		end else begin
			repeat (4) begin
				@(negedge clk);
				requireTrue(nSlave && nDtack && !wbReq.cyc, r.name,
					"card responded to a cycle that is not its own");
			end
		end
		// end of cycle
		nFCS = 1'b1;
		DOE = 1'b0;
		nDs = 4'hF;
		compareValue(r.name, "wb cycles", {31'h0, cardAccess}, wbCount - wbBefore);
		compareValue(r.name, "nCfgOut", {31'h0, r.expCfgOut}, {31'h0, nCfgOut});
	endtask

	initial begin
		nIORST = 1'b0;
		sense = 1'b1;
		nCfgIn = 1'b0;
		readIn = 1'b1;
		adIn = '0;
		aIn = '0;
		fc = 2'b01;
		nFCS = 1'b1;
		DOE = 1'b0;
		nDs = 4'hF;
		sdIn = '0;
		wbRsp = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'hA5, i[7:0], ~i[7:0], i[7:0] ^ 8'h3C};
		end
		// name, reset, addr, read, fc, ds, wdata, slave, expected data, nCfgOut
		addRow("reset", 1, 0, 1, 2'b01, 4'hF, 0, 0, 0, 1);
		addRow("cfg type hi", 0, 32'hFF000000, 1, 2'b01, 4'h0, 0, 1, nibbleWord(erType, 0, 0), 1);
		addRow("cfg type lo", 0, 32'hFF000100, 1, 2'b10, 4'h0, 0, 1, nibbleWord(erType, 1, 0), 1);
		addRow("cfg prod hi", 0, 32'hFF000004, 1, 2'b01, 4'h0, 0, 1, nibbleWord(product, 0, 1), 1);
		addRow("cfg prod lo", 0, 32'hFF000104, 1, 2'b01, 4'h0, 0, 1, nibbleWord(product, 1, 1), 1);
		addRow("cfg base", 0, 32'hFF000044, 0, 2'b01, 4'h0, 32'h40000000, 1, 0, 0);
		addRow("cfg gone", 0, 32'hFF000000, 1, 2'b01, 4'h0, 0, 0, 0, 0);
		addRow("wr full a", 0, 32'h40000010, 0, 2'b01, 4'h0, 32'h11223344, 1, 0, 0);
		addRow("wr part a", 0, 32'h40000010, 0, 2'b01, 4'h5, 32'hAABBCCDD, 1, 0, 0);
		addRow("rd a", 0, 32'h40000010, 1, 2'b01, 4'h0, 0, 1, 32'hAA22CC44, 0);
		addRow("wr full b", 0, 32'h40000020, 0, 2'b10, 4'h0, 32'h55667788, 1, 0, 0);
		addRow("wr hi b", 0, 32'h40000020, 0, 2'b10, 4'h7, 32'h99000000, 1, 0, 0);
		addRow("wr lo b", 0, 32'h40000020, 0, 2'b01, 4'hE, 32'h000000EE, 1, 0, 0);
		addRow("rd b", 0, 32'h40000020, 1, 2'b10, 4'h0, 0, 1, 32'h996677EE, 0);
		addRow("other base", 0, 32'h41000010, 1, 2'b01, 4'h0, 0, 0, 0, 0);
		addRow("fc 00", 0, 32'h40000010, 1, 2'b00, 4'h0, 0, 0, 0, 0);
		addRow("fc 11 rd", 0, 32'h40000010, 1, 2'b11, 4'h0, 0, 0, 0, 0);
		addRow("fc 11 wr", 0, 32'h40000030, 0, 2'b11, 4'h0, 32'h12345678, 0, 0, 0);
		addRow("reset 2", 1, 0, 1, 2'b01, 4'hF, 0, 0, 0, 1);
		addRow("shutup", 0, 32'hFF00004C, 0, 2'b01, 4'h0, 0, 1, 0, 0);
		addRow("cfg shut", 0, 32'hFF000000, 1, 2'b01, 4'h0, 0, 0, 0, 0);
		// a shut-up card refuses the base write and so never maps card space
		addRow("base shut", 0, 32'hFF000044, 0, 2'b01, 4'h0, 32'h40000000, 0, 0, 0);
		addRow("card shut", 0, 32'h40000010, 1, 2'b01, 4'h0, 0, 0, 0, 0);
		cycleLimit = rowCount * 30 + 50;
		for (int i = 0; i < rowCount; i++) begin
			cur = rows[i];
			if (cur.isReset) begin
				applyReset(cur);
			end else begin
				applyCycle(cur);
			end
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: z3Slave.f
+incdir+rtl
rtl/z3BusPkg.sv
rtl/wbPkg.sv
rtl/z3AddrDecode.sv
rtl/z3Autoconfig.sv
rtl/z3CycleFsm.sv
rtl/z3DataLanes.sv
rtl/z3Slave.sv
test/z3SlaveTb.sv
